/* include/ahb_mtx_defines.svh */
// Port count and bus widths are fixed at compile time; more than 4 ports also needs a wider MTX_IDX_W
`ifndef AHB_MTX_DEFINES_SVH
`define AHB_MTX_DEFINES_SVH

// ------------------------------
// AHB bus widths
// ------------------------------
`define AHB_ADDR_W    32        // HADDR width
`define AHB_DATA_W    32        // HWDATA width
`define AHB_USER_W    4         // HAUSER and HWUSER width
`define AHB_PROT_W    4         // HPROT width
`define AHB_MASTER_W  4         // HMASTER width
`define AHB_SIZE_W    3         // HSIZE width
`define AHB_BURST_W   3         // HBURST width, passed through only

// ------------------------------
// Matrix shape
// ------------------------------
`define MTX_N_PORTS   3         // Bus-switch inputs on this slave
`define MTX_IDX_W     2         // Bits to name one input port

// ------------------------------
// Simulation limits
// ------------------------------
`define MTX_SIM_SEED     16'd65 // LFSR start value
`define MTX_SIM_CYCLES   2000   // Cycles of random traffic
`define MTX_SIM_TIMEOUT  2500   // Hard stop for a hung run

`endif

/* src/ahb_mtx_pkg.sv */
// Types for a 3-port output stage; struct field order is the bit order on the slave, sel at the top
`include "ahb_mtx_defines.svh"

package ahb_mtx_pkg;

  // ------------------------------
  // Transfer type
  // ------------------------------
  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,                        // No transfer
    BUSY   = 2'b01,                        // Burst paused by master
    NONSEQ = 2'b10,                        // First beat or single
    SEQ    = 2'b11                         // Remaining burst beats
  } htrans_t;

  // ------------------------------
  // Port indexing
  // ------------------------------
  typedef logic [`MTX_IDX_W-1:0]   port_idx_t;  // Names port 0 to N-1
  typedef logic [`MTX_N_PORTS-1:0] port_vec_t;  // One bit per input port

  // ------------------------------
  // Address phase payload
  // ------------------------------
  typedef struct packed
  {
    logic                      sel;        // HSEL
    logic [`AHB_ADDR_W-1:0]    addr;       // HADDR
    logic [`AHB_USER_W-1:0]    auser;      // HAUSER
    htrans_t                   trans;      // HTRANS
    logic                      write;      // HWRITE
    logic [`AHB_SIZE_W-1:0]    size;       // HSIZE
    logic [`AHB_BURST_W-1:0]   burst;      // HBURST, not decoded
    logic [`AHB_PROT_W-1:0]    prot;       // HPROT
    logic [`AHB_MASTER_W-1:0]  master;     // HMASTER
    logic                      mastlock;   // HMASTLOCK
  } ahb_addr_ctrl_t;

  // ------------------------------
  // Data phase payload
  // ------------------------------
  typedef struct packed
  {
    logic [`AHB_DATA_W-1:0]    wdata;      // HWDATA
    logic [`AHB_USER_W-1:0]    wuser;      // HWUSER
  } ahb_wdata_t;

endpackage

/* src/ahb_mtx_port_mux.sv */
// Combinational port selector; an index at or above the port count gives zero
`include "ahb_mtx_defines.svh"

module ahb_mtx_port_mux
  import ahb_mtx_pkg::*;
#(
  parameter type payload_t = ahb_wdata_t   // Address or data payload
)
(
  input  payload_t   i_payload [`MTX_N_PORTS],  // One payload per port
  input  port_idx_t  i_idx,                     // Port to forward
  input  logic       i_valid,                   // Low forces zero out
  output payload_t   o_payload                  // Selected payload
);

  // ------------------------------
  // Selection
  // ------------------------------
  always_comb
  begin : p_mux
    o_payload = '0;                        // Idle bus when unowned
    if (i_valid)
    begin
      for (int p = 0; p < `MTX_N_PORTS; p++)
      begin
        if (i_idx == port_idx_t'(p))
          o_payload = i_payload[p];        // Route this port
      end
    end

    // Upstream registers only ever hold a real port number
    if (i_valid)
    begin
      a_idx_range : assert ((i_idx < `MTX_N_PORTS) !== 1'b0)
        else $error("Port index %0d out of range", i_idx);
    end
  end

endmodule

/* src/ahb_mtx_arbiter.sv */
// Round-robin arbiter; holds on BUSY/SEQ or lock only, HBURST length is never counted
`include "ahb_mtx_defines.svh"

module ahb_mtx_arbiter
  import ahb_mtx_pkg::*;
(
  input  logic            HCLK,            // AHB clock
  input  logic            HRESETn,         // Sync reset, active low
  input  port_vec_t       i_port_sel,      // HSEL of each input port
  input  port_vec_t       i_held_tran,     // Held transfer flag per port
  input  ahb_addr_ctrl_t  i_sel_addr,      // Muxed slave address phase
  input  logic            i_hreadymux,     // HREADYMUXM, gates all updates
  output port_idx_t       o_grant_idx,     // Granted port
  output logic            o_no_port,       // No port owns the slave
  output port_vec_t       o_active         // One-hot active per port
);

  // ------------------------------
  // Declarations
  // ------------------------------
  port_vec_t  req;                         // Port requests
  port_idx_t  grant_idx;                   // Current owner
  logic       no_port;                     // Slave unowned
  logic       hsel_lock;                   // Lock kept across HSEL drop
  logic       next_hsel_lock;              // Next hsel_lock
  logic       hlock_arb;                   // Lock seen by the arbiter
  logic       burst_hold;                  // Mid-burst, keep owner
  logic       hold;                        // Keep current grant
  logic       rr_found;                    // Some port requests
  port_idx_t  rr_idx;                      // Next port in rotation

  // Request only when the port holds a transfer for this slave
  assign req = i_held_tran & i_port_sel;

  // ------------------------------
  // Locked sequence tracking
  // ------------------------------
  // A master may address another slave inside a locked sequence, which
  // drops HSEL here; hsel_lock remembers that the lock started on this slave
  assign next_hsel_lock = (i_sel_addr.sel && i_sel_addr.trans[1] && i_sel_addr.mastlock) ? 1'b1 :
                          (!i_sel_addr.mastlock)                                         ? 1'b0 :
                          hsel_lock;

  always_ff @(posedge HCLK)
  begin : p_hsel_lock
    if (!HRESETn)
      hsel_lock <= 1'b0;                   // No lock out of reset
    else if (i_hreadymux)
      hsel_lock <= next_hsel_lock;         // Track on accepted cycles
  end

  // Mastlock counts only when selected or already locked here
  assign hlock_arb = i_sel_addr.mastlock & (i_sel_addr.sel | hsel_lock);

  // ------------------------------
  // Hold and rotation
  // ------------------------------
  assign burst_hold = (i_sel_addr.trans == BUSY) || (i_sel_addr.trans == SEQ);
  assign hold       = !no_port && (burst_hold || hlock_arb);

  // First requester after grant_idx, the current owner checked last
  always_comb
  begin : p_rr_pick
    int cand;                              // Candidate port number
    rr_found = 1'b0;
    rr_idx   = grant_idx;
    for (int k = 1; k <= `MTX_N_PORTS; k++)
    begin
      cand = int'(grant_idx) + k;
      if (cand >= `MTX_N_PORTS)
        cand = cand - `MTX_N_PORTS;        // Wrap around the ports
      if (!rr_found && req[cand])
      begin
        rr_found = 1'b1;
        rr_idx   = port_idx_t'(cand);
      end
    end
  end

  // ------------------------------
  // Grant register
  // ------------------------------
  always_ff @(posedge HCLK)
  begin : p_grant_reg
    if (!HRESETn)
    begin
      grant_idx <= '0;                     // Port 0 first in line
      no_port   <= 1'b1;                   // Slave idle after reset
    end
    else if (i_hreadymux)
    begin
      if (hold)
      begin
        grant_idx <= grant_idx;            // Burst or lock keeps owner
        no_port   <= 1'b0;
      end
      else if (rr_found)
      begin
        grant_idx <= rr_idx;               // Next requester wins
        no_port   <= 1'b0;
      end
      else
        no_port   <= 1'b1;                 // Nobody asks, index kept
    end
  end

  // ------------------------------
  // Active decode
  // ------------------------------
  always_comb
  begin : p_active
    o_active = '0;
    for (int p = 0; p < `MTX_N_PORTS; p++)
    begin
      if (!no_port && (grant_idx == port_idx_t'(p)))
        o_active[p] = 1'b1;                // Owner only
    end
  end

  assign o_grant_idx = grant_idx;
  assign o_no_port   = no_port;

  // ------------------------------
  // Assertions
  // ------------------------------
  // At most one input port may drive the slave
  a_active_onehot : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    $onehot0(o_active)
  ) else $error("o_active not one-hot: %b", o_active);

  // A stalled data phase must freeze ownership
  a_grant_frozen : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    !i_hreadymux |=> ($stable(grant_idx) && $stable(no_port))
  ) else $error("Grant changed while HREADYMUXM low");

endmodule

/* src/ahb_mtx_data_phase.sv */
// Data phase owner tracks the address phase by one accepted cycle; HWDATA always comes from some port
`include "ahb_mtx_defines.svh"

module ahb_mtx_data_phase
  import ahb_mtx_pkg::*;
(
  input  logic        HCLK,                          // AHB clock
  input  logic        HRESETn,                       // Sync reset, active low
  input  port_idx_t   i_grant_idx,                   // Address phase owner
  input  logic        i_slave_sel,                   // HSEL on the slave
  input  ahb_wdata_t  i_port_wdata [`MTX_N_PORTS],   // Write data per port
  input  logic        i_hreadyout,                   // Slave HREADYOUT
  output logic        o_hreadymux,                   // HREADYMUXM
  output ahb_wdata_t  o_slave_wdata                  // HWDATA and HWUSER
);

  // ------------------------------
  // Declarations
  // ------------------------------
  port_idx_t  data_idx;                    // Data phase owner
  logic       slave_sel;                   // Slave in data phase
  logic       hreadymux;                   // Internal HREADYMUXM

  // ------------------------------
  // Data phase registers
  // ------------------------------
  always_ff @(posedge HCLK)
  begin : p_data_idx
    if (!HRESETn)
      data_idx <= '0;                      // Port 0 by default
    else if (hreadymux)
      data_idx <= i_grant_idx;             // Owner moves to data phase
  end

  always_ff @(posedge HCLK)
  begin : p_slave_sel
    if (!HRESETn)
      slave_sel <= 1'b0;                   // Nothing pending
    else if (hreadymux)
      slave_sel <= i_slave_sel;            // Accepted HSEL
  end

  // ------------------------------
  // HREADYMUXM
  // ------------------------------
  // Slave ready counts only when the slave holds a data phase
  assign hreadymux   = slave_sel ? i_hreadyout : 1'b1;
  assign o_hreadymux = hreadymux;

  // ------------------------------
  // Write data routing
  // ------------------------------
  ahb_mtx_port_mux #(
    .payload_t  (ahb_wdata_t)
  ) u_wdata_mux (
    .i_payload  (i_port_wdata),
    .i_idx      (data_idx),
    .i_valid    (1'b1),                    // Always an owner
    .o_payload  (o_slave_wdata)
  );

  // ------------------------------
  // Assertions
  // ------------------------------
  // Without a selected slave the output stage never stalls
  a_ready_unsel : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    !slave_sel |-> o_hreadymux
  ) else $error("HREADYMUXM low with no slave data phase");

endmodule

/* src/ahb_mtx_output_stage.sv */
// Output stage for one shared slave; HRESP and read data bypass this block, port count set by define
`include "ahb_mtx_defines.svh"

module ahb_mtx_output_stage
  import ahb_mtx_pkg::*;
(
  input  logic            HCLK,                          // AHB clock
  input  logic            HRESETn,                       // Sync reset, active low
  input  ahb_addr_ctrl_t  i_port_addr  [`MTX_N_PORTS],   // Address phase per port
  input  ahb_wdata_t      i_port_wdata [`MTX_N_PORTS],   // Write data per port
  input  port_vec_t       i_held_tran,                   // Held transfer flags
  input  logic            i_hreadyout,                   // Slave HREADYOUT
  output port_vec_t       o_active,                      // Active per port
  output ahb_addr_ctrl_t  o_slave_addr,                  // Slave address phase
  output ahb_wdata_t      o_slave_wdata,                 // Slave write data
  output logic            o_hreadymux                    // HREADYMUXM
);

  // ------------------------------
  // Internal wires
  // ------------------------------
  port_vec_t  port_sel;                    // HSEL of each port
  port_idx_t  grant_idx;                   // Arbiter owner
  logic       no_port;                     // Slave unowned
  logic       hreadymux;                   // Accepted cycle strobe

  // Collect per-port HSEL
  for (genvar p = 0; p < `MTX_N_PORTS; p++)
  begin : g_port_sel
    assign port_sel[p] = i_port_addr[p].sel;
  end

  // ------------------------------
  // Arbitration
  // ------------------------------
  ahb_mtx_arbiter u_output_arb (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port_sel   (port_sel),
    .i_held_tran  (i_held_tran),
    .i_sel_addr   (o_slave_addr),          // Feedback of routed control
    .i_hreadymux  (hreadymux),
    .o_grant_idx  (grant_idx),
    .o_no_port    (no_port),
    .o_active     (o_active)
  );

  // ------------------------------
  // Address phase routing
  // ------------------------------
  ahb_mtx_port_mux #(
    .payload_t  (ahb_addr_ctrl_t)
  ) u_addr_mux (
    .i_payload  (i_port_addr),
    .i_idx      (grant_idx),
    .i_valid    (!no_port),                // Zero struct when idle
    .o_payload  (o_slave_addr)
  );

  // ------------------------------
  // Data phase
  // ------------------------------
  ahb_mtx_data_phase u_data_phase (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_grant_idx    (grant_idx),
    .i_slave_sel    (o_slave_addr.sel),
    .i_port_wdata   (i_port_wdata),
    .i_hreadyout    (i_hreadyout),
    .o_hreadymux    (hreadymux),
    .o_slave_wdata  (o_slave_wdata)
  );

  assign o_hreadymux = hreadymux;

endmodule

/* testbench/tb_ahb_mtx_output_stage.sv */
// Random traffic for 3 ports only; masters hold their address phase while HREADYMUXM is low
`include "ahb_mtx_defines.svh"

module tb_ahb_mtx_output_stage
  import ahb_mtx_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // ------------------------------
  // DUT signals
  // ------------------------------
  logic            HCLK;
  logic            HRESETn;
  ahb_addr_ctrl_t  port_addr  [`MTX_N_PORTS];  // Address phase per port
  ahb_wdata_t      port_wdata [`MTX_N_PORTS];  // Write data per port
  port_vec_t       held_tran;
  logic            hreadyout;
  port_vec_t       o_active;
  ahb_addr_ctrl_t  o_slave_addr;
  ahb_wdata_t      o_slave_wdata;
  logic            o_hreadymux;

  // ------------------------------
  // Model state and bookkeeping
  // ------------------------------
  int              m_grant;                // Model grant_idx
  logic            m_no_port;              // Model no_port
  logic            m_hsel_lock;            // Model hsel_lock
  int              m_data_idx;             // Model data_idx
  logic            m_slave_sel;            // Model slave_sel
  logic [15:0]     lfsr;                   // Stimulus source
  int              lock_cnt [`MTX_N_PORTS];  // Remaining locked cycles
  logic            stalled;                // Last edge was not accepted
  ahb_addr_ctrl_t  prev_addr;              // Expected slave struct at last check
  port_vec_t       prev_active;
  int              errors;
  int              checks;
  int              n_burst_hold;           // Burst holds under contention
  int              n_lock_nosel;           // Lock holds with HSEL low
  int              cycle_cnt = 0;

  ahb_mtx_output_stage ahb_mtx_output_stage_i (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_port_addr    (port_addr),
    .i_port_wdata   (port_wdata),
    .i_held_tran    (held_tran),
    .i_hreadyout    (hreadyout),
    .o_active       (o_active),
    .o_slave_addr   (o_slave_addr),
    .o_slave_wdata  (o_slave_wdata),
    .o_hreadymux    (o_hreadymux)
  );

  initial
  begin : clock_gen
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;             // 20 ns period
  end

  always @(posedge HCLK)
    cycle_cnt <= cycle_cnt + 1;

  // Fibonacci LFSR with taps 16 14 13 11 and one step per bit
  function automatic logic [31:0] lfsr_take(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic ahb_addr_ctrl_t expected_addr();
    return m_no_port ? ahb_addr_ctrl_t'('0) : port_addr[m_grant];
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("[FAIL] %0t %s expected %h found %h", $time, name, exp, got);
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic drive_inputs();
    hreadyout = (lfsr_take(2) != 0);       // Ready about 3 in 4
    if (stalled)
      return;                              // AHB masters hold during a stall
    for (int p = 0; p < `MTX_N_PORTS; p++)
    begin
      port_addr[p].sel    = (lfsr_take(2) != 0);
      port_addr[p].addr   = lfsr_take(32);
      port_addr[p].auser  = lfsr_take(4);
      port_addr[p].trans  = htrans_t'(lfsr_take(2));
      port_addr[p].write  = lfsr_take(1);
      port_addr[p].size   = lfsr_take(3);
      port_addr[p].burst  = lfsr_take(3);
      port_addr[p].prot   = lfsr_take(4);
      port_addr[p].master = lfsr_take(4);
      if (lock_cnt[p] > 0)
      begin
        port_addr[p].mastlock = 1'b1;      // Sequence still locked
        lock_cnt[p]--;
      end
      else
      begin
        port_addr[p].mastlock = 1'b0;
        if (lfsr_take(5) == 0)
          lock_cnt[p] = 3 + int'(lfsr_take(3));  // Rare and several cycles long
      end
      held_tran[p]        = (lfsr_take(2) != 0);
      port_wdata[p].wdata = lfsr_take(32);
      port_wdata[p].wuser = lfsr_take(4);
    end
  endtask

  // ------------------------------
  // Checks just before the edge
  // ------------------------------
  task automatic check_outputs();
    ahb_addr_ctrl_t exp_addr;
    port_vec_t      exp_active;
    logic           exp_ready;
    exp_addr   = expected_addr();
    exp_active = m_no_port ? port_vec_t'(0) : port_vec_t'(1 << m_grant);
    exp_ready  = m_slave_sel ? hreadyout : 1'b1;
    check_value("o_slave_addr", exp_addr, o_slave_addr);
    check_value("o_active", exp_active, o_active);
    check_value("o_hreadymux", exp_ready, o_hreadymux);
    check_value("o_slave_wdata", port_wdata[m_data_idx], o_slave_wdata);
    if (stalled)
    begin
      check_value("o_slave_addr in stall", prev_addr, o_slave_addr);
      check_value("o_active in stall", prev_active, o_active);
    end
    prev_addr   = exp_addr;
    prev_active = exp_active;
    stalled     = !exp_ready;
  endtask

  // ------------------------------
  // Reference model, one clock edge
  // ------------------------------
  task automatic step_model();
    ahb_addr_ctrl_t sa;
    logic           locked;
    logic           in_burst;
    logic           keep;
    logic           found;
    logic           others;
    int             c;
    int             next;
    if (stalled)
      return;                              // Nothing moves without HREADYMUXM
    sa       = expected_addr();
    locked   = sa.mastlock && (sa.sel || m_hsel_lock);
    in_burst = (sa.trans == BUSY) || (sa.trans == SEQ);
    keep     = !m_no_port && (in_burst || locked);
    others   = 1'b0;
    found    = 1'b0;
    next     = m_grant;
    for (int k = 1; k <= `MTX_N_PORTS; k++)
    begin
      c = (m_grant + k) % `MTX_N_PORTS;   // Rotate from the current owner
      if (held_tran[c] && port_addr[c].sel)
      begin
        if (c != m_grant)
          others = 1'b1;
        if (!found)
          next = c;
        found = 1'b1;
      end
    end
    if (keep && in_burst && others)
      n_burst_hold++;
    if (keep && locked && !sa.sel)
      n_lock_nosel++;
    m_data_idx  = m_grant;                 // Data phase follows address
    m_slave_sel = sa.sel;
    if (sa.sel && sa.trans[1] && sa.mastlock)
      m_hsel_lock = 1'b1;
    else if (!sa.mastlock)
      m_hsel_lock = 1'b0;
    if (keep)
      m_no_port = 1'b0;
    else if (found)
    begin
      m_grant   = next;
      m_no_port = 1'b0;
    end
    else
      m_no_port = 1'b1;                    // Index kept
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin : stimulus
    lfsr        = `MTX_SIM_SEED;
    HRESETn     = 1'b0;
    hreadyout   = 1'b1;
    held_tran   = '0;
    for (int p = 0; p < `MTX_N_PORTS; p++)
    begin
      port_addr[p]  = '0;
      port_wdata[p] = '0;
      lock_cnt[p]   = 0;
    end
    m_grant      = 0;
    m_no_port    = 1'b1;
    m_hsel_lock  = 1'b0;
    m_data_idx   = 0;
    m_slave_sel  = 1'b0;
    stalled      = 1'b0;
    prev_addr    = '0;
    prev_active  = '0;
    errors       = 0;
    checks       = 0;
    n_burst_hold = 0;
    n_lock_nosel = 0;
    repeat (8) @(posedge HCLK);
    #2;
    HRESETn = 1'b1;
    #16;
    check_value("o_active after reset", '0, o_active);
    check_value("o_slave_addr after reset", '0, o_slave_addr);
    check_value("o_hreadymux after reset", 1, o_hreadymux);
    step_model();
    for (int cyc = 0; cyc < `MTX_SIM_CYCLES; cyc++)
    begin
      @(posedge HCLK);
      #2;                                  // Drive clear of the edge
      drive_inputs();
      #16;
      check_outputs();
      step_model();
    end
    assert (n_burst_hold > 0)
    else
    begin
      errors++;
      $display("No grant was ever held through a burst while another port requested");
    end
    assert (n_lock_nosel > 0)
    else
    begin
      errors++;
      $display("No locked sequence ever kept the slave after its HSEL dropped");
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial
  begin : timeout_guard
    wait (cycle_cnt >= `MTX_SIM_TIMEOUT);
    $display("Run did not finish within %0d cycles", `MTX_SIM_TIMEOUT);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Errors found");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
src/ahb_mtx_pkg.sv
src/ahb_mtx_port_mux.sv
src/ahb_mtx_arbiter.sv
src/ahb_mtx_data_phase.sv
src/ahb_mtx_output_stage.sv
testbench/tb_ahb_mtx_output_stage.sv
